// ==== bench/stream_writer_tb.sv ====
`timescale 1ns/100ps

module stream_writer_tb;

    import stream_pkg::*;
    import host_pkg::*;

    // Six jobs of at most a few hundred cycles each, even with random ready
    // The limit leaves a wide margin above their sum
    localparam int MAX_CYCLES = 20000;
    // Cycles between an accepted request and its completion
    localparam int CPL_DELAY = 5;

    logic          clk;
    logic          reset_synced;
    logic          i_in_valid;
    stream_beat_t  i_in;
    logic          o_in_ready;
    logic          i_buf_valid;
    buffer_desc_t  i_buf;
    logic          o_buf_ready;
    logic          o_req_valid;
    write_req_t    o_req;
    logic          i_req_ready;
    logic          o_out_valid;
    stream_beat_t  o_out;
    logic          i_out_ready;
    logic          i_cpl_valid;
    completion_t   i_cpl;
    logic          o_notify_valid;
    notify_value_t o_notify;
    logic          i_notify_ready;

    integer seed;
    int cycles = 0;
    string test_name;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // Host model controls that the tests change
    logic rand_ready = 1'b0;
    logic foreign_cpl = 1'b0;
    int cpl_allowed = 1000000;
    int cpl_due[$];

    // Stimulus, expected responses and what the host model saw
    stream_beat_t  in_beats[$];
    stream_beat_t  exp_out[$];
    stream_beat_t  got_out[$];
    write_req_t    exp_req[$];
    write_req_t    got_req[$];
    notify_value_t exp_notify[$];
    notify_value_t got_notify[$];

    stream_writer i_stream_writer (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a job never finished", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Host model
    // ------------------------------------------------------------------

    function automatic logic ready_draw();
        // Ready about three cycles out of four
        return ($random(seed) & 3) != 0;
    endfunction

    // Handshakes are sampled on the edge and inputs change 0.5 ns later
    always @(posedge clk) begin : host_model
        logic req_fire;
        req_fire = reset_synced && o_req_valid && i_req_ready;
        if (req_fire) begin
            got_req.push_back(o_req);
        end
        if (reset_synced && o_out_valid && i_out_ready) begin
            got_out.push_back(o_out);
        end
        if (reset_synced && o_notify_valid && i_notify_ready) begin
            got_notify.push_back(o_notify);
        end
        #0.5;
        if (req_fire) begin
            cpl_due.push_back(cycles + CPL_DELAY);
        end
        i_out_ready = rand_ready ? ready_draw() : 1'b1;
        i_req_ready = rand_ready ? ready_draw() : 1'b1;
        i_notify_ready = rand_ready ? ready_draw() : 1'b1;
        i_cpl_valid = 1'b0;
        i_cpl.dest = 3'd0;
        if (cpl_due.size() > 0 && cpl_allowed > 0 && cpl_due[0] <= cycles) begin
            void'(cpl_due.pop_front());
            cpl_allowed--;
            i_cpl_valid = 1'b1;
            i_cpl.dest = STREAM_ID;
        end else if (foreign_cpl && (($random(seed) & 3) == 0)) begin
            // Completions of other streams share the bus and must be ignored
            i_cpl_valid = 1'b1;
            i_cpl.dest = ($random(seed) & 1) ? 3'd0 : 3'd6;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus and expected values
    // ------------------------------------------------------------------

    // Full beats, then a partial or empty final beat carrying last
    task automatic build_stream(input int nbytes);
        stream_beat_t beat;
        int left;
        int take;
        int in_xfer;
        left = nbytes;
        in_xfer = 0;
        do begin
            take = (left > DATA_BYTES) ? DATA_BYTES : left;
            left -= take;
            beat.data = {$random(seed), $random(seed)};
            beat.keep = {DATA_BYTES{1'b1}} >> (DATA_BYTES - take);
            beat.last = (left == 0);
            in_beats.push_back(beat);
            // On the host side last closes each transfer
            // An empty beat never leaves
            if (take > 0) begin
                in_xfer += take;
                beat.last = (in_xfer == TRANSFER_BYTES) || (left == 0);
                if (beat.last) begin
                    in_xfer = 0;
                end
                exp_out.push_back(beat);
            end
        end while (left > 0);
    endtask

    task automatic expect_request(input vaddr_t vaddr, input int len);
        write_req_t req;
        req.vaddr = vaddr;
        req.len = transfer_len_t'(len);
        req.dest = STREAM_ID;
        exp_req.push_back(req);
    endtask

    task automatic expect_notify(input int bytes, input logic last);
        notify_value_t value;
        value.last = last;
        value.bytes_written = 28'(bytes);
        value.stream_id = STREAM_ID;
        exp_notify.push_back(value);
    endtask

    task automatic send_stream();
        while (in_beats.size() > 0) begin
            i_in_valid = 1'b1;
            i_in = in_beats.pop_front();
            do @(posedge clk); while (!o_in_ready);
            #0.5;
        end
        i_in_valid = 1'b0;
    endtask

    task automatic give_buffer(input vaddr_t vaddr, input vaddr_t size);
        i_buf_valid = 1'b1;
        i_buf.vaddr = vaddr;
        i_buf.size = size;
        do @(posedge clk); while (!o_buf_ready);
        #0.5;
        i_buf_valid = 1'b0;
    endtask

    task automatic wait_for_notify(input int count);
        do begin
            @(posedge clk);
            #0.5;
        end while (got_notify.size() < count);
    endtask

    task automatic collect_beats();
        do begin
            @(posedge clk);
            #0.5;
        end while (got_out.size() < exp_out.size());
    endtask

    task automatic watch_notify_quiet(input int ncycles);
        repeat (ncycles) begin
            @(posedge clk);
            if (o_notify_valid) begin
                $display("%s: notification raised while completions were outstanding",
                         test_name);
                note_error();
            end
        end
        #0.5;
    endtask

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic compare_flag(input string what, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Error %s %s: expected %b, actual %b", test_name, what, exp, got);
            note_error();
        end
    endtask

    task automatic compare_req(input write_req_t exp, input write_req_t got);
        if (got !== exp) begin
            $display("Error %s request: expected vaddr %h len %0d dest %0d, actual %h %0d %0d",
                     test_name, exp.vaddr, exp.len, exp.dest, got.vaddr, got.len, got.dest);
            note_error();
        end
    endtask

    task automatic compare_beat(input stream_beat_t exp, input stream_beat_t got);
        if (got !== exp) begin
            $display("Error %s beat: expected %h/%h/%b, actual %h/%h/%b", test_name,
                     exp.data, exp.keep, exp.last, got.data, got.keep, got.last);
            note_error();
        end
    endtask

    task automatic compare_notify(input notify_value_t exp, input notify_value_t got);
        if (got !== exp) begin
            $display("Error %s notify: expected last %b bytes %0d id %0d, actual %b %0d %0d",
                     test_name, exp.last, exp.bytes_written, exp.stream_id,
                     got.last, got.bytes_written, got.stream_id);
            note_error();
        end
    endtask

    task automatic check_results();
        int k;
        if (got_req.size() != exp_req.size() || got_out.size() != exp_out.size() ||
                got_notify.size() != exp_notify.size()) begin
            $display("%s: saw %0d requests, %0d beats, %0d notifications, expected %0d %0d %0d",
                     test_name, got_req.size(), got_out.size(), got_notify.size(),
                     exp_req.size(), exp_out.size(), exp_notify.size());
            note_error();
        end
        for (k = 0; k < exp_req.size() && k < got_req.size(); k++) begin
            compare_req(exp_req[k], got_req[k]);
        end
        for (k = 0; k < exp_out.size() && k < got_out.size(); k++) begin
            compare_beat(exp_out[k], got_out[k]);
        end
        for (k = 0; k < exp_notify.size() && k < got_notify.size(); k++) begin
            compare_notify(exp_notify[k], got_notify[k]);
        end
    endtask

    task automatic finish_test();
        check_results();
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", test_name, test_errors);
        end
        test_errors = 0;
        exp_req.delete();
        got_req.delete();
        exp_out.delete();
        got_out.delete();
        exp_notify.delete();
        got_notify.delete();
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------

    // Right after reset only the descriptor and the empty FIFOs accept anything
    task automatic idle_after_reset();
        test_name = "idle after reset";
        @(posedge clk);
        compare_flag("buffer ready", 1'b1, o_buf_ready);
        compare_flag("input ready", 1'b1, o_in_ready);
        compare_flag("request valid", 1'b0, o_req_valid);
        compare_flag("output valid", 1'b0, o_out_valid);
        compare_flag("notify valid", 1'b0, o_notify_valid);
        #0.5;
        finish_test();
    endtask

    // Two full transfers and a 24 byte tail with last out on beats 8, 16 and 19
    task automatic partial_last_transfer(input string name, input vaddr_t base);
        test_name = name;
        build_stream(152);
        expect_request(base, 64);
        expect_request(base + 64, 64);
        expect_request(base + 128, 24);
        expect_notify(152, 1'b1);
        fork
            send_stream();
            give_buffer(base, 1024);
        join
        wait_for_notify(1);
        finish_test();
    endtask

    // The region closes after 128 bytes and the rest goes to a second region
    task automatic allocation_full();
        test_name = "allocation full";
        build_stream(200);
        expect_request(48'h2000_0000, 64);
        expect_request(48'h2000_0040, 64);
        expect_notify(128, 1'b0);
        expect_request(48'h2100_0000, 64);
        expect_request(48'h2100_0040, 8);
        expect_notify(72, 1'b1);
        fork
            send_stream();
            give_buffer(48'h2000_0000, 128);
        join
        wait_for_notify(1);
        give_buffer(48'h2100_0000, 1024);
        wait_for_notify(2);
        finish_test();
    endtask

    // Completions are released one at a time while foreign ones keep arriving
    task automatic completion_gating();
        test_name = "completion gating";
        cpl_allowed = 0;
        foreign_cpl = 1'b1;
        build_stream(96);
        expect_request(48'h3000_0000, 64);
        expect_request(48'h3000_0040, 32);
        expect_notify(96, 1'b1);
        fork
            send_stream();
            give_buffer(48'h3000_0000, 256);
        join
        collect_beats();
        watch_notify_quiet(40);
        cpl_allowed = 1;
        while (cpl_due.size() > 1) begin
            @(posedge clk);
            #0.5;
        end
        watch_notify_quiet(40);
        cpl_allowed = 1;
        wait_for_notify(1);
        cpl_allowed = 1000000;
        foreign_cpl = 1'b0;
        finish_test();
    endtask

    task automatic back_pressure();
        rand_ready = 1'b1;
        foreign_cpl = 1'b1;
        partial_last_transfer("back pressure", 48'h4000_0000);
        rand_ready = 1'b0;
        foreign_cpl = 1'b0;
    endtask

    // A lone empty beat closes the stream without any request
    task automatic empty_end();
        test_name = "empty end";
        build_stream(0);
        expect_notify(0, 1'b1);
        fork
            send_stream();
            give_buffer(48'h5000_0000, 64);
        join
        wait_for_notify(1);
        finish_test();
    endtask

    initial begin
        seed = 66453;
        reset_synced = 1'b0;
        i_in_valid = 1'b0;
        i_in = '0;
        i_buf_valid = 1'b0;
        i_buf = '0;
        i_req_ready = 1'b0;
        i_out_ready = 1'b0;
        i_cpl_valid = 1'b0;
        i_cpl = '0;
        i_notify_ready = 1'b0;
        repeat (16) @(posedge clk);
        #0.5;
        reset_synced = 1'b1;
        idle_after_reset();
        partial_last_transfer("partial last transfer", 48'h1000_0000);
        allocation_full();
        completion_gating();
        back_pressure();
        empty_end();
        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/stream_pkg.sv
verilog/host_pkg.sv
verilog/sync_fifo.sv
verilog/transfer_splitter.sv
verilog/transfer_sequencer.sv
verilog/stream_writer.sv
bench/stream_writer_tb.sv

// ==== verilog/host_pkg.sv ====
package host_pkg;

    // ------------------------------------------------------------------
    // Host addressing
    // ------------------------------------------------------------------

    localparam int VADDR_BITS = 48;

    // Id this writer places on requests and expects back on completions
    localparam logic [2:0] STREAM_ID = 3'd2;

    typedef logic [VADDR_BITS-1:0] vaddr_t;

    // Host memory region handed to the writer
    // Size is a nonzero multiple of the transfer length
    typedef struct packed {
        vaddr_t vaddr;
        vaddr_t size;
    } buffer_desc_t;

    // ------------------------------------------------------------------
    // Request and completion queues
    // ------------------------------------------------------------------

    // One local write of len bytes starting at vaddr
    typedef struct packed {
        vaddr_t                    vaddr;
        stream_pkg::transfer_len_t len;
        logic [2:0]                dest;
    } write_req_t;

    // One completion per accepted request, tagged with the stream it belongs to
    typedef struct packed {
        logic [2:0] dest;
    } completion_t;

    // Value raised to the host when a region is closed
    // Bytes written is limited to 2^28, which bounds the region size
    typedef struct packed {
        logic        last;
        logic [27:0] bytes_written;
        logic [2:0]  stream_id;
    } notify_value_t;

endpackage

// ==== verilog/stream_pkg.sv ====
package stream_pkg;

    // ------------------------------------------------------------------
    // Data path geometry
    // ------------------------------------------------------------------

    // Width of one stream beat in bits
    localparam int DATA_BITS = 64;
    // Bytes carried by one full beat
    localparam int DATA_BYTES = DATA_BITS / 8;

    // Largest write that goes to the host in one request
    // Must stay a whole number of beats
    localparam int TRANSFER_BYTES = 64;

    // Wide enough to hold TRANSFER_BYTES itself, not just TRANSFER_BYTES-1
    localparam int LEN_BITS = $clog2(TRANSFER_BYTES) + 1;
    // Wide enough to hold the ones-count of a full keep
    localparam int KEEP_COUNT_BITS = $clog2(DATA_BYTES) + 1;

    // ------------------------------------------------------------------
    // Buffering
    // ------------------------------------------------------------------

    // Room for two whole transfers so the input can run ahead of the host
    localparam int DATA_FIFO_DEPTH = 2 * (TRANSFER_BYTES / DATA_BYTES);
    localparam int LEN_FIFO_DEPTH = 16;

    // One beat of the byte stream
    // Keep is all ones except on a beat that carries last
    typedef struct packed {
        logic [DATA_BITS-1:0]  data;
        logic [DATA_BYTES-1:0] keep;
        logic                  last;
    } stream_beat_t;

    // Byte count of one transfer, zero marks an empty end of stream
    typedef logic [LEN_BITS-1:0] transfer_len_t;

endpackage

// ==== verilog/stream_writer.sv ====
`timescale 1ns/100ps

module stream_writer (
    input  logic                     clk,
    input  logic                     reset_synced,

    // Input byte stream
    input  logic                     i_in_valid,
    input  stream_pkg::stream_beat_t i_in,
    output logic                     o_in_ready,

    // Host memory region
    input  logic                     i_buf_valid,
    input  host_pkg::buffer_desc_t   i_buf,
    output logic                     o_buf_ready,

    // Write requests
    output logic                     o_req_valid,
    output host_pkg::write_req_t     o_req,
    input  logic                     i_req_ready,

    // Payload towards the host
    output logic                     o_out_valid,
    output stream_pkg::stream_beat_t o_out,
    input  logic                     i_out_ready,

    // Completions
    input  logic                     i_cpl_valid,
    input  host_pkg::completion_t    i_cpl,

    // Notification
    output logic                     o_notify_valid,
    output host_pkg::notify_value_t  o_notify,
    input  logic                     i_notify_ready
);

    import stream_pkg::*;

    // ------------------------------------------------------------------
    // Splitter to FIFOs
    // ------------------------------------------------------------------

    logic          split_beat_valid;
    stream_beat_t  split_beat;
    logic          split_beat_ready;
    logic          split_len_valid;
    transfer_len_t split_len;
    logic          split_len_ready;

    // ------------------------------------------------------------------
    // FIFOs to sequencer
    // ------------------------------------------------------------------

    logic          fifo_beat_valid;
    stream_beat_t  fifo_beat;
    logic          fifo_beat_ready;
    logic          fifo_len_valid;
    transfer_len_t fifo_len;
    logic          fifo_len_ready;

    transfer_splitter i_transfer_splitter (
        .clk          (clk),
        .reset_synced (reset_synced),
        .i_in_valid   (i_in_valid),
        .i_in         (i_in),
        .o_in_ready   (o_in_ready),
        .o_beat_valid (split_beat_valid),
        .o_beat       (split_beat),
        .i_beat_ready (split_beat_ready),
        .o_len_valid  (split_len_valid),
        .o_len        (split_len),
        .i_len_ready  (split_len_ready)
    );

    sync_fifo #(
        .WIDTH ($bits(stream_beat_t)),
        .DEPTH (DATA_FIFO_DEPTH)
    ) i_data_fifo (
        .clk          (clk),
        .reset_synced (reset_synced),
        .i_valid      (split_beat_valid),
        .i_data       (split_beat),
        .o_ready      (split_beat_ready),
        .o_valid      (fifo_beat_valid),
        .o_data       (fifo_beat),
        .i_ready      (fifo_beat_ready)
    );

    sync_fifo #(
        .WIDTH (LEN_BITS),
        .DEPTH (LEN_FIFO_DEPTH)
    ) i_len_fifo (
        .clk          (clk),
        .reset_synced (reset_synced),
        .i_valid      (split_len_valid),
        .i_data       (split_len),
        .o_ready      (split_len_ready),
        .o_valid      (fifo_len_valid),
        .o_data       (fifo_len),
        .i_ready      (fifo_len_ready)
    );

    transfer_sequencer i_transfer_sequencer (
        .clk            (clk),
        .reset_synced   (reset_synced),
        .i_buf_valid    (i_buf_valid),
        .i_buf          (i_buf),
        .o_buf_ready    (o_buf_ready),
        .i_len_valid    (fifo_len_valid),
        .i_len          (fifo_len),
        .o_len_ready    (fifo_len_ready),
        .i_beat_valid   (fifo_beat_valid),
        .i_beat         (fifo_beat),
        .o_beat_ready   (fifo_beat_ready),
        .o_req_valid    (o_req_valid),
        .o_req          (o_req),
        .i_req_ready    (i_req_ready),
        .o_out_valid    (o_out_valid),
        .o_out          (o_out),
        .i_out_ready    (i_out_ready),
        .i_cpl_valid    (i_cpl_valid),
        .i_cpl          (i_cpl),
        .o_notify_valid (o_notify_valid),
        .o_notify       (o_notify),
        .i_notify_ready (i_notify_ready)
    );

endmodule

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             reset_synced,

    // Write side
    input  logic             i_valid,
    input  logic [WIDTH-1:0] i_data,
    output logic             o_ready,

    // Read side shows the first word without a read request
    output logic             o_valid,
    output logic [WIDTH-1:0] o_data,
    input  logic             i_ready
);

    logic [WIDTH-1:0] mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    logic push;
    logic pop;

    assign o_ready = count != ($clog2(DEPTH+1))'(DEPTH);
    assign o_valid = count != '0;
    assign o_data = mem[rd_ptr];

    assign push = i_valid & o_ready;
    assign pop = o_valid & i_ready;

    // Payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Pointers wrap back to zero after DEPTH-1
    always_ff @(posedge clk) begin
        if (!reset_synced) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // A push and a pop in the same cycle leave the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/transfer_sequencer.sv ====
`timescale 1ns/100ps

module transfer_sequencer (
    input  logic                      clk,
    input  logic                      reset_synced,

    // Host memory region
    input  logic                      i_buf_valid,
    input  host_pkg::buffer_desc_t    i_buf,
    output logic                      o_buf_ready,

    // Transfer lengths from the length FIFO
    input  logic                      i_len_valid,
    input  stream_pkg::transfer_len_t i_len,
    output logic                      o_len_ready,

    // Beats from the data FIFO
    input  logic                      i_beat_valid,
    input  stream_pkg::stream_beat_t  i_beat,
    output logic                      o_beat_ready,

    // Write requests to the host
    output logic                      o_req_valid,
    output host_pkg::write_req_t      o_req,
    input  logic                      i_req_ready,

    // Payload stream that follows each request
    output logic                      o_out_valid,
    output stream_pkg::stream_beat_t  o_out,
    input  logic                      i_out_ready,

    // Completions are always accepted
    input  logic                      i_cpl_valid,
    input  host_pkg::completion_t     i_cpl,

    // Notification to the host
    output logic                      o_notify_valid,
    output host_pkg::notify_value_t   o_notify,
    input  logic                      i_notify_ready
);

    import stream_pkg::*;
    import host_pkg::*;

    typedef enum logic [2:0] {
        WAIT_DESC,
        REQUEST,
        TRANSFER,
        WAIT_COMPLETION,
        WAIT_NOTIFY,
        DONE
    } seq_state_t;

    seq_state_t state;

    // Region being filled, vaddr advances by each requested length
    vaddr_t vaddr;
    vaddr_t alloc_size;
    vaddr_t bytes_written;
    vaddr_t num_requests;
    vaddr_t num_completions;
    logic last_transfer;

    // Length held for the current or next transfer
    transfer_len_t len_q;
    logic len_held;
    logic len_release;

    // Progress inside the current transfer
    transfer_len_t bytes_in_xfer;
    transfer_len_t bytes_in_xfer_next;
    logic [KEEP_COUNT_BITS-1:0] beat_bytes;
    logic xfer_done;
    logic beat_fire;
    logic drop_empty;
    logic cpl_hit;

    // ------------------------------------------------------------------
    // Handshake decode
    // ------------------------------------------------------------------

    assign beat_bytes = KEEP_COUNT_BITS'($countones(i_beat.keep));
    assign bytes_in_xfer_next = bytes_in_xfer + LEN_BITS'(beat_bytes);
    assign xfer_done = bytes_in_xfer_next == len_q;
    assign beat_fire = (state == TRANSFER) & i_beat_valid & i_out_ready;

    // A zero length means the stream ended on an empty beat
    // That beat is still in the data FIFO and gets dropped here
    assign drop_empty = (state == REQUEST) & len_held & (len_q == '0) & i_beat_valid;

    // The held length is given up when its bytes are all forwarded
    assign len_release = (beat_fire & xfer_done) | drop_empty;
    assign o_len_ready = ~len_held | len_release;

    assign cpl_hit = i_cpl_valid & (i_cpl.dest == STREAM_ID);

    assign o_buf_ready = state == WAIT_DESC;
    assign o_req_valid = (state == REQUEST) & len_held & (len_q != '0);
    assign o_req.vaddr = vaddr;
    assign o_req.len = len_q;
    assign o_req.dest = STREAM_ID;

    // Beats pass unchanged except that last now marks the end of a transfer
    assign o_out_valid = (state == TRANSFER) & i_beat_valid;
    assign o_out.data = i_beat.data;
    assign o_out.keep = i_beat.keep;
    assign o_out.last = xfer_done;
    assign o_beat_ready = ((state == TRANSFER) & i_out_ready) | drop_empty;

    assign o_notify_valid = state == WAIT_NOTIFY;
    assign o_notify.last = last_transfer;
    assign o_notify.bytes_written = bytes_written[27:0];
    assign o_notify.stream_id = STREAM_ID;

    // ------------------------------------------------------------------
    // Length register
    // ------------------------------------------------------------------

    // Registering the length puts a cycle between its arrival and the request
    always_ff @(posedge clk) begin
        if (!reset_synced) begin
            len_held <= 1'b0;
        end else if (i_len_valid && o_len_ready) begin
            len_held <= 1'b1;
        end else if (len_release) begin
            len_held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_len_valid && o_len_ready) begin
            len_q <= i_len;
        end
    end

    // ------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!reset_synced) begin
            state <= WAIT_DESC;
            bytes_written <= '0;
            num_requests <= '0;
            num_completions <= '0;
            last_transfer <= 1'b0;
            bytes_in_xfer <= '0;
        end else begin
            // Completions count in every state, a new region clears them below
            if (cpl_hit) begin
                num_completions <= num_completions + 1'b1;
            end

            case (state)
                WAIT_DESC: begin
                    if (i_buf_valid) begin
                        vaddr <= i_buf.vaddr;
                        alloc_size <= i_buf.size;
                        bytes_written <= '0;
                        num_requests <= '0;
                        num_completions <= '0;
                        last_transfer <= 1'b0;
                        state <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (o_req_valid && i_req_ready) begin
                        vaddr <= vaddr + vaddr_t'(len_q);
                        bytes_written <= bytes_written + vaddr_t'(len_q);
                        num_requests <= num_requests + 1'b1;
                        bytes_in_xfer <= '0;
                        state <= TRANSFER;
                    end else if (drop_empty) begin
                        // Earlier requests of this region may still be in flight
                        last_transfer <= 1'b1;
                        state <= WAIT_COMPLETION;
                    end
                end
                TRANSFER: begin
                    if (beat_fire) begin
                        if (!xfer_done) begin
                            bytes_in_xfer <= bytes_in_xfer_next;
                        end else if (i_beat.last ||
                                alloc_size < bytes_written + vaddr_t'(TRANSFER_BYTES)) begin
                            // Stream ended or another full transfer would overrun the region
                            last_transfer <= i_beat.last;
                            state <= WAIT_COMPLETION;
                        end else begin
                            state <= REQUEST;
                        end
                    end
                end
                WAIT_COMPLETION: begin
                    if (num_completions == num_requests) begin
                        state <= WAIT_NOTIFY;
                    end
                end
                WAIT_NOTIFY: begin
                    if (i_notify_ready) begin
                        state <= DONE;
                    end
                end
                // One turnaround cycle before the next region is taken
                DONE: begin
                    state <= WAIT_DESC;
                end
                default: begin
                    state <= WAIT_DESC;
                end
            endcase
        end
    end

endmodule

// ==== verilog/transfer_splitter.sv ====
`timescale 1ns/100ps

module transfer_splitter (
    input  logic                      clk,
    input  logic                      reset_synced,

    // Byte stream from outside
    input  logic                      i_in_valid,
    input  stream_pkg::stream_beat_t  i_in,
    output logic                      o_in_ready,

    // Beats towards the data FIFO
    output logic                      o_beat_valid,
    output stream_pkg::stream_beat_t  o_beat,
    input  logic                      i_beat_ready,

    // Transfer lengths towards the length FIFO
    output logic                      o_len_valid,
    output stream_pkg::transfer_len_t o_len,
    input  logic                      i_len_ready
);

    import stream_pkg::*;

    // Bytes taken so far for the transfer being built
    transfer_len_t count;
    transfer_len_t count_next;
    logic [KEEP_COUNT_BITS-1:0] beat_bytes;
    logic split;
    logic accept;

    // ------------------------------------------------------------------
    // Length cutting
    // ------------------------------------------------------------------

    assign beat_bytes = KEEP_COUNT_BITS'($countones(i_in.keep));
    assign count_next = count + LEN_BITS'(beat_bytes);

    // A transfer closes on the beat that fills it or on the end of stream
    assign split = (count_next == LEN_BITS'(TRANSFER_BYTES)) | i_in.last;

    // Beat and length must enter their FIFOs together, so both need room
    assign o_in_ready = i_beat_ready & i_len_ready;
    assign accept = i_in_valid & o_in_ready;

    // Each push is qualified by the other FIFO only, never by its own ready
    assign o_beat_valid = i_in_valid & i_len_ready;
    assign o_beat = i_in;

    assign o_len_valid = i_in_valid & i_beat_ready & split;
    // The total includes the closing beat, which may add zero bytes
    assign o_len = count_next;

    always_ff @(posedge clk) begin
        if (!reset_synced) begin
            count <= '0;
        end else if (accept) begin
            if (split) begin
                count <= '0;
            end else begin
                count <= count_next;
            end
        end
    end

endmodule
